// File: design/rx_dsp_pkg.sv
package rx_dsp_pkg;

	localparam int lane_count = 8; // symbols carried by one clock word.
	localparam int sample_bits = 8; // signed ADC code width.
	localparam int error_bits = 8; // signed slicer error width.
	localparam int target_level = 32; // ideal magnitude of a data symbol.
	localparam int frame_bits = 64; // one capture memory word.

	// the polynomial x^7 + x^6 + 1 predicts each bit from the bits 6 and 7 places back.
	localparam int prbs_order = 7;
	localparam int prbs_tap = 6;

	localparam int flag_pad_bits = frame_bits - 2 * lane_count; // unused tail of a flag frame.

	localparam logic signed [error_bits-1:0] target_error = error_bits'(target_level);

	typedef logic signed [sample_bits-1:0] sample_t;
	typedef logic signed [error_bits-1:0] error_t;

	// lane 0 sits in the least significant slot.
	typedef struct packed {
		sample_t [lane_count-1:0] lane;
	} sample_word_t;

	typedef struct packed {
		error_t [lane_count-1:0] lane; // signed error per lane.
	} error_frame_t;

	typedef struct packed {
		logic [flag_pad_bits-1:0] pad; // always zero.
		logic [lane_count-1:0] bits; // decided bits of the word.
		logic [lane_count-1:0] flags; // PRBS mismatch per lane.
	} flag_frame_t;

endpackage : rx_dsp_pkg

// File: design/err_trk_pkg.sv
package err_trk_pkg;

	// the memory word width is the data-path frame width.
	import rx_dsp_pkg::frame_bits;
	export rx_dsp_pkg::frame_bits;

	localparam int addr_bits = 8; // capture memory address width.
	localparam int mem_depth = 256; // capture memory entries.
	localparam int frames_per_capture = 2; // error frame, then flag frame.
	localparam int count_bits = $clog2(frames_per_capture);

	localparam logic [addr_bits-1:0] last_addr = addr_bits'(mem_depth - 1);
	localparam logic [count_bits-1:0] last_frame = count_bits'(frames_per_capture - 1);

	typedef enum logic [1:0] {
		ready, // waiting for a trigger.
		store, // writing the frames of a capture.
		done // memory frozen for debug readout.
	} tracker_state_t;

	typedef struct packed {
		logic enable; // rearm the tracker from done.
		logic read; // stop after the current capture.
		logic [addr_bits-1:0] addr; // readout address in done.
	} dbg_cmd_t;

	typedef struct packed {
		logic done;
		logic [frame_bits-1:0] rdata; // memory word at the previous cycle's address.
	} dbg_status_t;

endpackage : err_trk_pkg

// File: design/error_slicer.sv
module error_slicer import rx_dsp_pkg::*; (
	input logic clk,
	input logic rstb,
	input sample_word_t samples,
	output error_frame_t err_frame
);

	error_frame_t next_frame;

	// each lane is compared with the data level of its own polarity.
	always_comb begin
		for (int i = 0; i < lane_count; i++) begin
			if (!samples.lane[i][sample_bits-1]) begin
				next_frame.lane[i] = error_bits'(samples.lane[i]) - target_error;
			end else begin
				next_frame.lane[i] = error_bits'(samples.lane[i]) + target_error;
			end
		end
	end

	// the result is range-limited to -96..95, so no clipping is needed.

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			err_frame <= '0;
		end else begin
			err_frame <= next_frame; // aligned with the PRBS checker output.
		end
	end

endmodule : error_slicer

// File: design/prbs_checker.sv
module prbs_checker import rx_dsp_pkg::*; (
	input logic clk,
	input logic rstb,
	input logic [lane_count-1:0] bits,
	output flag_frame_t flag_frame
);

	logic [prbs_order-1:0] history; // last received bits with the oldest at bit 0.
	logic [lane_count+prbs_order-1:0] stream; // history followed by this word.
	logic [lane_count-1:0] predicted;
	logic [lane_count-1:0] mismatch;

	// lane 0 is earliest in time, so it follows the newest history bit.
	assign stream = {bits, history};

	// Lane i sits at stream position i + prbs_order.
	always_comb begin
		for (int i = 0; i < lane_count; i++) begin
			predicted[i] = stream[i + prbs_order - prbs_tap] ^ stream[i];
		end
	end

	assign mismatch = bits ^ predicted; // received bits feed the history, so it resyncs.

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			history <= '0;
			flag_frame <= '0;
		end else begin
			history <= stream[lane_count+prbs_order-1 -: prbs_order]; // keep the newest bits.
			flag_frame.pad <= '0;
			flag_frame.bits <= bits;
			flag_frame.flags <= mismatch;
		end
	end

	// The tracker stores the whole frame, so a dirty pad would show up in readout.
	pad_zero_a: assert property (
		@(posedge clk) disable iff (!rstb)
		flag_frame.pad == '0
	) else $error("prbs_checker: flag frame pad field is not zero.");

endmodule : prbs_checker

// File: design/capture_ram.sv
module capture_ram import err_trk_pkg::*; (
	input logic clk,
	input logic we_n,
	input logic [addr_bits-1:0] addr,
	input logic [frame_bits-1:0] wdata,
	output logic [frame_bits-1:0] rdata
);

	logic [frame_bits-1:0] mem [mem_depth];

	// single port with active-low write enable.
	always_ff @(posedge clk) begin
		if (!we_n) begin
			mem[addr] <= wdata;
		end
	end

	// The read is registered every cycle; a write cycle returns the old word.
	always_ff @(posedge clk) begin
		rdata <= mem[addr];
	end

endmodule : capture_ram

// File: design/error_tracker.sv
module error_tracker import rx_dsp_pkg::*, err_trk_pkg::*; (
	input logic clk,
	input logic rstb,
	input logic trigger,
	input error_frame_t err_frame,
	input flag_frame_t flag_frame,
	input dbg_cmd_t dbg_cmd,
	output dbg_status_t dbg_status,
	output logic mem_we_n,
	output logic [addr_bits-1:0] mem_addr,
	output logic [frame_bits-1:0] mem_wdata,
	input logic [frame_bits-1:0] mem_rdata
);

	tracker_state_t state;
	logic [count_bits-1:0] frame_cnt; // frame being written in store.
	logic [addr_bits-1:0] write_addr;
	logic we_n;

	// the error frame is latched into slot 0 and the flag frame into slot 1.
	logic [frames_per_capture-1:0][frame_bits-1:0] hold_frames;

	logic at_end; // current write lands on the last address.
	logic last_write; // current write is the final frame of a capture.
	logic capture_start; // this edge latches a new capture.

	assign at_end = (write_addr == last_addr);
	assign last_write = (frame_cnt == last_frame);

	// a capture starts from ready, or directly after the final write of the previous one.
	always_comb begin
		capture_start = 1'b0;
		if (trigger) begin
			if (state == ready) begin
				capture_start = 1'b1;
			end else if (state == store && last_write && !at_end) begin
				capture_start = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (capture_start) begin
			hold_frames <= {flag_frame, err_frame}; // both frames belong to the same word.
		end
	end

	always_ff @(posedge clk or negedge rstb) begin
		if (!rstb) begin
			state <= ready;
			frame_cnt <= '0;
			write_addr <= '0;
			we_n <= 1'b1;
		end else begin
			case (state)
				ready: begin
					if (trigger) begin
						state <= store;
						we_n <= 1'b0; // frame 0 goes out on the next edge.
					end else if (dbg_cmd.read) begin
						state <= done;
					end
				end
				store: begin
					if (at_end) begin
						// Memory is full; freeze it for readout.
						state <= done;
						we_n <= 1'b1;
						frame_cnt <= '0;
					end else begin
						write_addr <= write_addr + 1'b1;
						if (!last_write) begin
							frame_cnt <= frame_cnt + 1'b1;
						end else begin
							frame_cnt <= '0;
							if (!trigger) begin
								we_n <= 1'b1;
								state <= dbg_cmd.read ? done : ready;
							end
						end
					end
				end
				done: begin
					we_n <= 1'b1;
					if (dbg_cmd.enable) begin
						write_addr <= '0; // the next capture overwrites from the start.
						state <= ready;
					end
				end
				default: begin
					state <= ready;
					we_n <= 1'b1;
				end
			endcase
		end
	end

	assign mem_we_n = we_n;
	assign mem_addr = (state == done) ? dbg_cmd.addr : write_addr;
	assign mem_wdata = hold_frames[frame_cnt];

	assign dbg_status.done = (state == done);
	assign dbg_status.rdata = mem_rdata; // one cycle behind dbg_cmd.addr.

	// The debug address drives the memory in done, so a write would corrupt it.
	no_write_in_done_a: assert property (
		@(posedge clk) disable iff (!rstb)
		(state == done) |-> mem_we_n
	) else $error("error_tracker: memory write enabled in done state.");

	// the counter only moves while the frames of a capture are written.
	frame_cnt_idle_a: assert property (
		@(posedge clk) disable iff (!rstb)
		(state != store) |-> (frame_cnt == '0)
	) else $error("error_tracker: frame counter not cleared outside the store state.");

	// Only the rearm in done may bring the write address back to 0.
	no_addr_wrap_a: assert property (
		@(posedge clk) disable iff (!rstb)
		(state == store) |=> (write_addr >= $past(write_addr))
	) else $error("error_tracker: write address wrapped during a capture.");

endmodule : error_tracker

// File: design/rx_monitor_top.sv
module rx_monitor_top import rx_dsp_pkg::*, err_trk_pkg::*; (
	input logic clk,
	input logic rstb,
	input sample_word_t samples,
	input logic [lane_count-1:0] bits,
	input logic trigger,
	input dbg_cmd_t dbg_cmd,
	output dbg_status_t dbg_status
);

	error_frame_t err_frame; // slicer result, one cycle after the samples.
	flag_frame_t flag_frame; // checker result, aligned with err_frame.

	logic mem_we_n;
	logic [addr_bits-1:0] mem_addr;
	logic [frame_bits-1:0] mem_wdata;
	logic [frame_bits-1:0] mem_rdata;

	error_slicer error_slicer_i (
		.clk(clk),
		.rstb(rstb),
		.samples(samples),
		.err_frame(err_frame)
	);

	prbs_checker prbs_checker_i (
		.clk(clk),
		.rstb(rstb),
		.bits(bits),
		.flag_frame(flag_frame)
	);

	error_tracker error_tracker_i (
		.clk(clk),
		.rstb(rstb),
		.trigger(trigger),
		.err_frame(err_frame),
		.flag_frame(flag_frame),
		.dbg_cmd(dbg_cmd),
		.dbg_status(dbg_status),
		.mem_we_n(mem_we_n),
		.mem_addr(mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	// behavioural stand-in for the capture SRAM.
	capture_ram capture_ram_i (
		.clk(clk),
		.we_n(mem_we_n),
		.addr(mem_addr),
		.wdata(mem_wdata),
		.rdata(mem_rdata)
	);

endmodule : rx_monitor_top

// File: sim/rx_monitor_tb.sv
module rx_monitor_tb import rx_dsp_pkg::*, err_trk_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	logic clk = 1'b0;
	logic rstb;
	sample_word_t samples;
	logic [lane_count-1:0] bits;
	logic trigger;
	dbg_cmd_t dbg_cmd;
	dbg_status_t dbg_status;

	int seed = 14;
	int value_errors = 0;
	int control_errors = 0;
	int timeout_errors = 0;
	string test_name;

	logic [6:0] gen_state = 7'h5a; // transmit PRBS7 generator with the newest bit at bit 0.
	logic [6:0] rx_hist = '0; // received bits as the checker sees them with the newest at bit 0.
	int inject_lane = -1; // lane to flip in the next word or none when negative.

	error_frame_t cur_err; // expected slicer result of the word just driven.
	flag_frame_t cur_flag; // expected checker result of the word just driven.
	logic [frame_bits-1:0] exp_mem [mem_depth];
	int model_waddr = 0;

	logic check_on;
	logic [frame_bits-1:0] check_exp;
	logic valid_d = 1'b0;
	logic [frame_bits-1:0] exp_d = '0;
	logic [addr_bits-1:0] addr_d = '0;
	logic done_allowed; // set once a read was requested or the memory filled up.

	rx_monitor_top rx_monitor_top_i (
		.clk(clk),
		.rstb(rstb),
		.samples(samples),
		.bits(bits),
		.trigger(trigger),
		.dbg_cmd(dbg_cmd),
		.dbg_status(dbg_status)
	);

	always #2 clk = ~clk;

	// the readout shows up one cycle after the address, so the expectation is delayed too.
	always @(posedge clk) begin
		valid_d <= check_on;
		exp_d <= check_exp;
		addr_d <= dbg_cmd.addr;
	end

	rdata_a: assert property (
		@(posedge clk) disable iff (!rstb)
		valid_d |-> dbg_status.rdata == exp_d
	) else begin
		value_errors++;
		$display("** Error [%s] address %0d: expected %h, actual %h", test_name,
			$sampled(addr_d), $sampled(exp_d), $sampled(dbg_status.rdata));
	end

	// done may only come from a read request or from a full memory.
	done_rise_a: assert property (
		@(posedge clk)
		$rose(dbg_status.done) |-> done_allowed
	) else begin
		control_errors++;
		$display("Done rose in test %s although no read was requested and memory was not full.",
			test_name);
	end

	// Slicer reference: distance of the sample from the data level of its polarity.
	function automatic error_t expected_error(input sample_t s);
		int v;
		v = s;
		if (v >= 0) begin
			v = v - target_level;
		end else begin
			v = v + target_level;
		end
		return error_t'(v);
	endfunction

	// drives one word and works out what slicer and checker must make of it.
	task automatic drive_word();
		sample_word_t s;
		logic [lane_count-1:0] b;
		logic [lane_count-1:0] fl;
		logic gen_bit;
		logic pred;
		int r;
		s = '0;
		b = '0;
		if (rstb) begin
			for (int i = 0; i < lane_count; i++) begin
				r = $random(seed);
				s.lane[i] = r[sample_bits-1:0];
				gen_bit = gen_state[5] ^ gen_state[6];
				gen_state = {gen_state[5:0], gen_bit};
				b[i] = gen_bit; // lane 0 goes out first.
			end
		end
		if (inject_lane >= 0) begin
			b[inject_lane] = ~b[inject_lane]; // single bit error on the line.
			inject_lane = -1;
		end
		for (int i = 0; i < lane_count; i++) begin
			pred = rx_hist[5] ^ rx_hist[6]; // bits 6 and 7 places back.
			fl[i] = b[i] ^ pred;
			rx_hist = {rx_hist[5:0], b[i]};
			cur_err.lane[i] = expected_error(s.lane[i]);
		end
		cur_flag = '0;
		cur_flag.bits = b;
		cur_flag.flags = fl;
		samples <= s;
		bits <= b;
	endtask

	task automatic tick();
		@(posedge clk);
		drive_word();
	endtask

	// the capture keeps the word driven one clock before trigger goes high.
	task automatic record_capture();
		exp_mem[model_waddr % mem_depth] = cur_err;
		exp_mem[(model_waddr + 1) % mem_depth] = cur_flag;
		model_waddr += frames_per_capture;
		if (model_waddr >= mem_depth) begin
			done_allowed <= 1'b1; // the tracker stops by itself here.
		end
	endtask

	// trigger stays high so that each capture follows the last one with no gap.
	task automatic capture_run(input int count, input logic with_read);
		for (int k = 0; k < 2 * count - 1; k++) begin
			if (k % 2 == 0) begin
				record_capture();
			end
			tick();
			trigger <= 1'b1;
		end
		tick();
		trigger <= 1'b0;
		dbg_cmd.read <= with_read;
		if (with_read) begin
			done_allowed <= 1'b1;
		end
	endtask

	task automatic wait_done(input int limit);
		int n;
		n = 0;
		@(negedge clk);
		while (!dbg_status.done && n < limit) begin
			tick();
			@(negedge clk);
			n++;
		end
		if (!dbg_status.done) begin
			timeout_errors++;
			$display("Timeout in test %s: done did not rise within %0d cycles.", test_name, limit);
		end
		tick();
		dbg_cmd.read <= 1'b0;
	endtask

	task automatic read_word(input int addr);
		tick();
		dbg_cmd.addr <= addr_bits'(addr);
		check_on <= 1'b1;
		check_exp <= exp_mem[addr];
	endtask

	// lets the last readout reach its check before anything else changes.
	task automatic finish_reads();
		tick();
		check_on <= 1'b0;
		repeat (3) tick();
	endtask

	task automatic rearm();
		tick();
		dbg_cmd.enable <= 1'b1;
		done_allowed <= 1'b0;
		model_waddr = 0;
		tick();
		dbg_cmd.enable <= 1'b0;
		tick();
	endtask

	initial begin
		samples = '0;
		bits = '0;
		trigger = 1'b0;
		dbg_cmd = '0;
		rstb = 1'b0;
		check_on = 1'b0;
		check_exp = '0;
		done_allowed = 1'b0;
		cur_err = '0;
		cur_flag = '0;

		test_name = "reset";
		repeat (16) tick(); // reset held for 16 clock cycles.
		rstb <= 1'b1;
		repeat (12) tick(); // long enough for the checker to lock on the stream.

		test_name = "error_capture";
		capture_run(1, 1'b1);
		wait_done(20);
		read_word(0);
		finish_reads();

		test_name = "flag_capture";
		read_word(1); // clean stream, so no flags expected.
		finish_reads();
		rearm();
		inject_lane = 1; // flags this lane, lane 7 and lane 0 of the next word.
		tick();
		capture_run(1, 1'b0);
		repeat (4) tick();
		inject_lane = 5; // the later flags land on lanes 3 and 4 of the next word.
		tick();
		tick();
		capture_run(1, 1'b1);
		wait_done(20);
		for (int a = 0; a < 4; a++) begin
			read_word(a);
		end
		finish_reads();

		test_name = "back_to_back";
		rearm();
		capture_run(3, 1'b1);
		wait_done(20);
		for (int a = 0; a < 6; a++) begin
			read_word(a);
		end
		finish_reads();

		test_name = "rearm";
		rearm();
		capture_run(1, 1'b0);
		repeat (6) tick(); // done has to stay low without a read.
		dbg_cmd.read <= 1'b1;
		done_allowed <= 1'b1;
		wait_done(20);
		read_word(0);
		read_word(1);
		read_word(2); // left over from the back-to-back run.
		finish_reads();

		test_name = "memory_full";
		rearm();
		capture_run(mem_depth / frames_per_capture, 1'b0);
		wait_done(20);
		read_word(0);
		read_word(mem_depth - 2);
		read_word(mem_depth - 1);
		finish_reads();

		repeat (4) tick();
		$display("Checks done: %0d value errors, %0d control errors, %0d timeouts.",
			value_errors, control_errors, timeout_errors);
		if (value_errors + control_errors + timeout_errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule : rx_monitor_tb

// File: filelist.f
design/rx_dsp_pkg.sv
design/err_trk_pkg.sv
design/error_slicer.sv
design/prbs_checker.sv
design/capture_ram.sv
design/error_tracker.sv
design/rx_monitor_top.sv
sim/rx_monitor_tb.sv
